/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := dds_lab_tb
FILELIST  := dds_lab.f
BUILD     := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)

/* bench/dds_lab_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_lab_tb
   import dds_pkg::*;
   import apb_pkg::*;
();

   localparam int max_cycles = 20000;   // whole run needs about 1000

   logic      CLK_50M = 1'b0;
   logic      reset_from_key;
   apb_req_t  apb_req;
   apb_rsp_t  apb_rsp;
   sample_t   sig_out;
   sample_t   mod_out;
   symbol_t   symbol;

   int        cycles = 0;
   int        exp_div = 16;
   int        hold_cnt = 0;     // cycles the previous symbol was held
   sample_t   prev_sig;
   symbol_t   prev_sym;
   sample_t   frozen [4];      // indexed by wave_sel
   mod_sel_t  cur_mod = 2'd0;
   logic      saw_check = 1'b0;
   logic      const_check = 1'b0;
   logic      period_check = 1'b0;
   logic      hold_check = 1'b0;
   logic      mod_check = 1'b0;
   apb_data_t rdata;
   apb_data_t ctrl_val;
   apb_data_t inc_val;
   apb_data_t div_val;
   apb_addr_t bad_addr;

   dds_lab_top #(
      .default_phase_inc (32'd258),
      .tick_div_reset    (32'd16),
      .lfsr_seed         (5'd1)
   ) dut0 (
      .CLK_50M        (CLK_50M),
      .reset_from_key (reset_from_key),
      .apb_req        (apb_req),
      .apb_rsp        (apb_rsp),
      .sig_out        (sig_out),
      .mod_out        (mod_out),
      .symbol         (symbol)
   );

   always #10 CLK_50M = ~CLK_50M;

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("Verification failed");
      $fatal(1, "run stopped");
   endtask

   // x^5 + x^3 + 1, shifting left
   function automatic symbol_t lfsr_step(input symbol_t s);
      lfsr_step = {s[3:0], s[4] ^ s[2]};
   endfunction

   function automatic sample_t mod_expect(input mod_sel_t sel, input symbol_t sym,
                                          input sample_t s, input sample_t c);
      case (sel)
         2'd0: mod_expect = sym[0] ? s : 12'd0;
         2'd1: mod_expect = s;
         2'd2:
         begin
            case (sym[1:0])
               2'd0: mod_expect = s;
               2'd1: mod_expect = c;
               2'd2: mod_expect = 12'hFFF - s;   // mirrored about mid scale
               2'd3: mod_expect = 12'hFFF - c;
            endcase
         end
         default: mod_expect = sym[0] ? 12'h800 : 12'd0;
      endcase
   endfunction

   // history for the checks and the run limit
   always @(posedge CLK_50M)
   begin
      prev_sig <= sig_out;
      prev_sym <= symbol;
      hold_cnt <= (symbol != prev_sym) ? 1 : hold_cnt + 1;
      cycles   <= cycles + 1;
      if (cycles == max_cycles)
         stop_on_error($sformatf("run timed out after %0d cycles", max_cycles));
   end

   //////////////////////////////////////////////////
   // APB master
   //////////////////////////////////////////////////
   task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                           input logic exp_err, output apb_data_t data_out);
      apb_req.paddr   = addr;
      apb_req.pwrite  = wr;
      apb_req.pwdata  = wdata;
      apb_req.psel    = 1'b1;
      apb_req.penable = 1'b0;
      @(posedge CLK_50M);
      #1;
      apb_req.penable = 1'b1;
      @(negedge CLK_50M);   // mid access cycle
      data_out = apb_rsp.prdata;
      assert (apb_rsp.pslverr == exp_err)
      else stop_on_error($sformatf("ERR %0t pslverr expected %b actual %b",
                                   $time, exp_err, apb_rsp.pslverr));
      @(posedge CLK_50M);
      #1;
      apb_req.psel    = 1'b0;
      apb_req.penable = 1'b0;
      apb_req.pwrite  = 1'b0;
   endtask

   task automatic write_reg(input apb_addr_t addr, input apb_data_t wdata);
      apb_data_t unused;
      apb_xfer(1'b1, addr, wdata, 1'b0, unused);
   endtask

   task automatic read_expect(input apb_addr_t addr, input apb_data_t exp, input string name);
      apb_data_t got;
      apb_xfer(1'b0, addr, '0, 1'b0, got);
      assert (got == exp)
      else stop_on_error($sformatf("ERR %0t %s expected %h actual %h", $time, name, exp, got));
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge CLK_50M);
      #1;
   endtask

   task automatic wait_symbol_change();
      @(negedge CLK_50M);
      while (symbol == prev_sym)
         @(negedge CLK_50M);
      @(posedge CLK_50M);
      #1;
   endtask

   //////////////////////////////////////////////////
   // checks sampled on the falling edge
   //////////////////////////////////////////////////
   idle_bus_quiet: assert property (@(negedge CLK_50M) disable iff (reset_from_key)
      !apb_req.psel |-> apb_rsp.prdata == '0 && !apb_rsp.pslverr)
      else stop_on_error($sformatf("ERR %0t prdata expected 0 actual %h, pslverr %b",
                                   $time, apb_rsp.prdata, apb_rsp.pslverr));

   bus_ready: assert property (@(negedge CLK_50M) disable iff (reset_from_key)
      apb_req.psel |-> apb_rsp.pready)
      else stop_on_error($sformatf("ERR %0t pready expected 1 actual 0", $time));

   symbol_nonzero: assert property (@(negedge CLK_50M) disable iff (reset_from_key)
      symbol != '0)
      else stop_on_error($sformatf("ERR %0t symbol expected nonzero actual 0", $time));

   symbol_follows_lfsr: assert property (@(negedge CLK_50M) disable iff (reset_from_key)
      symbol != prev_sym |-> symbol == lfsr_step(prev_sym))
      else stop_on_error($sformatf("ERR %0t symbol expected %h actual %h",
                                   $time, lfsr_step(prev_sym), symbol));

   symbol_period: assert property (@(negedge CLK_50M) disable iff (reset_from_key)
      period_check && symbol != prev_sym |-> hold_cnt == exp_div)
      else stop_on_error($sformatf("ERR %0t symbol period expected %0d actual %0d",
                                   $time, exp_div, hold_cnt));

   symbol_held: assert property (@(negedge CLK_50M) disable iff (reset_from_key)
      hold_check |-> symbol == prev_sym)
      else stop_on_error($sformatf("ERR %0t symbol expected %h actual %h",
                                   $time, prev_sym, symbol));

   saw_ramp: assert property (@(negedge CLK_50M) disable iff (reset_from_key)
      saw_check |-> sig_out == sample_t'(prev_sig + 12'd1))
      else stop_on_error($sformatf("ERR %0t sig_out expected %h actual %h",
                                   $time, sample_t'(prev_sig + 12'd1), sig_out));

   sig_frozen: assert property (@(negedge CLK_50M) disable iff (reset_from_key)
      const_check |-> sig_out == prev_sig)
      else stop_on_error($sformatf("ERR %0t sig_out expected %h actual %h",
                                   $time, prev_sig, sig_out));

   mod_rule: assert property (@(negedge CLK_50M) disable iff (reset_from_key)
      mod_check |-> mod_out == mod_expect(cur_mod, prev_sym, frozen[0], frozen[1]))
      else stop_on_error($sformatf("ERR %0t mod_out expected %h actual %h", $time,
                                   mod_expect(cur_mod, prev_sym, frozen[0], frozen[1]),
                                   mod_out));

   initial
   begin
      void'($urandom(41659));
      apb_req        = '0;
      reset_from_key = 1'b1;
      repeat (2) @(posedge CLK_50M);
      #1;
      reset_from_key = 1'b0;

      // symbol read before the divider first steps it
      read_expect(symbol_addr, 32'd1, "symbol");
      read_expect(ctrl_addr, 32'd0, "ctrl");
      read_expect(phase_inc_addr, 32'd258, "phase_inc");
      read_expect(tick_div_addr, 32'd16, "tick_div");

      // random readback
      ctrl_val = $urandom;
      inc_val  = $urandom;
      div_val  = $urandom;
      write_reg(ctrl_addr, ctrl_val);
      write_reg(phase_inc_addr, inc_val);
      write_reg(tick_div_addr, div_val);
      read_expect(ctrl_addr, ctrl_val & 32'h33, "ctrl");
      read_expect(phase_inc_addr, inc_val, "phase_inc");
      read_expect(tick_div_addr, div_val, "tick_div");

      // unmapped offset
      bad_addr = apb_addr_t'(32'h10 + ($urandom % 32'd240));
      apb_xfer(1'b1, bad_addr, ~inc_val, 1'b1, rdata);
      apb_xfer(1'b0, bad_addr, '0, 1'b1, rdata);
      assert (rdata == '0)
      else stop_on_error($sformatf("ERR %0t prdata expected 0 actual %h", $time, rdata));
      read_expect(ctrl_addr, ctrl_val & 32'h33, "ctrl");
      read_expect(phase_inc_addr, inc_val, "phase_inc");
      read_expect(tick_div_addr, div_val, "tick_div");
      apb_xfer(1'b1, symbol_addr, 32'h1F, 1'b0, rdata);   // read only

      //////////////////////////////////////////////////
      // sawtooth ramp then frozen phase
      //////////////////////////////////////////////////
      write_reg(tick_div_addr, 32'd16);
      write_reg(ctrl_addr, 32'(wave_saw));
      write_reg(phase_inc_addr, 32'h0010_0000);
      wait_cycles(4);
      saw_check = 1'b1;
      wait_cycles(40);
      saw_check = 1'b0;

      write_reg(phase_inc_addr, 32'd0);
      for (int w = 0; w < 4; w++)
      begin
         write_reg(ctrl_addr, 32'(w));
         wait_cycles(4);
         const_check = 1'b1;
         wait_cycles(10);
         frozen[w]   = sig_out;
         const_check = 1'b0;
      end
      assert (frozen[3] == (frozen[2][11] ? 12'hFFF : 12'd0))
      else stop_on_error($sformatf("ERR %0t square expected from saw %h actual %h",
                                   $time, frozen[2], frozen[3]));

      // symbol timing at two dividers and then held
      wait_symbol_change();
      period_check = 1'b1;
      repeat (4) wait_symbol_change();
      period_check = 1'b0;
      exp_div = 3 + int'($urandom % 32'd6);
      write_reg(tick_div_addr, 32'(exp_div));
      wait_symbol_change();
      period_check = 1'b1;
      repeat (6) wait_symbol_change();
      period_check = 1'b0;
      write_reg(tick_div_addr, 32'd0);
      wait_cycles(2);
      hold_check = 1'b1;
      wait_cycles(50);
      hold_check = 1'b0;

      // each modulation against the frozen carrier
      write_reg(tick_div_addr, 32'd2);
      for (int m = 0; m < 4; m++)
      begin
         cur_mod = mod_sel_t'(m);
         write_reg(ctrl_addr, {26'd0, cur_mod, 4'd0});
         wait_cycles(3);
         mod_check = 1'b1;
         wait_cycles(40);
         mod_check = 1'b0;
      end

      $display("Verification passed");
      $finish;
   end

endmodule

`default_nettype wire

/* dds_lab.f */
+incdir+include
logic/dds_pkg.sv
logic/apb_pkg.sv
logic/dds_regs.sv
logic/symbol_gen.sv
logic/dds_core.sv
logic/modulator.sv
logic/dds_lab_top.sv
bench/dds_lab_tb.sv

/* include/sine_quarter.svh */
`ifndef SINE_QUARTER_SVH
`define SINE_QUARTER_SVH

// first quadrant of sine, amplitude 2047, sampled at bin centres
// so the mirrored quadrant lines up without a repeated point
function automatic logic [10:0] sine_quarter(input logic [5:0] idx);
   case (idx)
      6'd0:  sine_quarter = 11'd25;
      6'd1:  sine_quarter = 11'd75;
      6'd2:  sine_quarter = 11'd126;
      6'd3:  sine_quarter = 11'd176;
      6'd4:  sine_quarter = 11'd226;
      6'd5:  sine_quarter = 11'd275;
      6'd6:  sine_quarter = 11'd325;
      6'd7:  sine_quarter = 11'd375;
      6'd8:  sine_quarter = 11'd424;
      6'd9:  sine_quarter = 11'd473;
      6'd10: sine_quarter = 11'd522;
      6'd11: sine_quarter = 11'd570;
      6'd12: sine_quarter = 11'd618;
      6'd13: sine_quarter = 11'd666;
      6'd14: sine_quarter = 11'd713;
      6'd15: sine_quarter = 11'd760;
      6'd16: sine_quarter = 11'd806;
      6'd17: sine_quarter = 11'd852;
      6'd18: sine_quarter = 11'd898;
      6'd19: sine_quarter = 11'd943;
      6'd20: sine_quarter = 11'd987;
      6'd21: sine_quarter = 11'd1031;
      6'd22: sine_quarter = 11'd1074;
      6'd23: sine_quarter = 11'd1116;
      6'd24: sine_quarter = 11'd1158;
      6'd25: sine_quarter = 11'd1199;
      6'd26: sine_quarter = 11'd1239;
      6'd27: sine_quarter = 11'd1279;
      6'd28: sine_quarter = 11'd1318;
      6'd29: sine_quarter = 11'd1356;
      6'd30: sine_quarter = 11'd1393;
      6'd31: sine_quarter = 11'd1430;
      6'd32: sine_quarter = 11'd1465;
      6'd33: sine_quarter = 11'd1500;
      6'd34: sine_quarter = 11'd1533;
      6'd35: sine_quarter = 11'd1566;
      6'd36: sine_quarter = 11'd1598;
      6'd37: sine_quarter = 11'd1629;
      6'd38: sine_quarter = 11'd1659;
      6'd39: sine_quarter = 11'd1688;
      6'd40: sine_quarter = 11'd1716;
      6'd41: sine_quarter = 11'd1743;
      6'd42: sine_quarter = 11'd1769;
      6'd43: sine_quarter = 11'd1793;
      6'd44: sine_quarter = 11'd1817;
      6'd45: sine_quarter = 11'd1840;
      6'd46: sine_quarter = 11'd1861;
      6'd47: sine_quarter = 11'd1881;
      6'd48: sine_quarter = 11'd1901;
      6'd49: sine_quarter = 11'd1919;
      6'd50: sine_quarter = 11'd1936;
      6'd51: sine_quarter = 11'd1951;
      6'd52: sine_quarter = 11'd1966;
      6'd53: sine_quarter = 11'd1979;
      6'd54: sine_quarter = 11'd1992;
      6'd55: sine_quarter = 11'd2003;
      6'd56: sine_quarter = 11'd2012;
      6'd57: sine_quarter = 11'd2021;
      6'd58: sine_quarter = 11'd2028;
      6'd59: sine_quarter = 11'd2035;
      6'd60: sine_quarter = 11'd2039;
      6'd61: sine_quarter = 11'd2043;
      6'd62: sine_quarter = 11'd2046;
      6'd63: sine_quarter = 11'd2047;
   endcase
endfunction

`endif

/* logic/apb_pkg.sv */
`default_nettype none

package apb_pkg;

   typedef logic [7:0]  apb_addr_t;   // byte address
   typedef logic [31:0] apb_data_t;

   //////////////////////////////////////////////////
   // bus bundles
   //////////////////////////////////////////////////
   typedef struct packed {
      apb_addr_t paddr;
      logic      psel;
      logic      penable;
      logic      pwrite;
      apb_data_t pwdata;
   } apb_req_t;

   typedef struct packed {
      apb_data_t prdata;
      logic      pready;
      logic      pslverr;
   } apb_rsp_t;

   // register map
   localparam apb_addr_t ctrl_addr      = 8'h00;   // [1:0] wave_sel, [5:4] mod_sel
   localparam apb_addr_t phase_inc_addr = 8'h04;
   localparam apb_addr_t tick_div_addr  = 8'h08;
   localparam apb_addr_t symbol_addr    = 8'h0C;   // read only, [4:0]

endpackage

`default_nettype wire

/* logic/dds_core.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_core
   import dds_pkg::*;
(
   input  wire        CLK_50M,
   input  wire        reset_from_key,
   input  wire        phase_t phase_inc,
   output waveforms_t waves
);

`include "sine_quarter.svh"

   localparam phase_t quarter_turn = 32'h4000_0000;

   phase_t phase;
   phase_t phase_cos;   // sine a quarter turn ahead

   // fold one quadrant of table into a full period
   function automatic sample_t fold_sine(input phase_t ph);
      logic [5:0]  idx;
      logic [10:0] amp;
      idx = ph[30] ? ~ph[29:24] : ph[29:24];   // odd quadrants run backwards
      amp = sine_quarter(idx);
      if (ph[31])
         fold_sine = sample_mid - sample_t'(amp);
      else
         fold_sine = sample_mid + sample_t'(amp);
   endfunction

   assign phase_cos = phase + quarter_turn;

   //////////////////////////////////////////////////
   // phase accumulator
   //////////////////////////////////////////////////
   always_ff @(posedge CLK_50M)
   begin
      if (reset_from_key)
         phase <= '0;
      else
         phase <= phase + phase_inc;   // wraps mod 2^32
   end

   // samples lag the phase by one clock
   always_ff @(posedge CLK_50M)
   begin
      waves.sin <= fold_sine(phase);
      waves.cos <= fold_sine(phase_cos);
      waves.squ <= {12{phase[31]}};
      waves.saw <= phase[31:20];
   end

endmodule

`default_nettype wire

/* logic/dds_lab_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_lab_top
   import dds_pkg::*;
   import apb_pkg::*;
#(
   parameter phase_t  default_phase_inc = 32'd258,
   parameter phase_t  tick_div_reset    = 32'd50_000_000,   // one symbol per second
   parameter symbol_t lfsr_seed         = 5'd1
)
(
   input  wire      CLK_50M,
   input  wire      reset_from_key,
   input  wire      apb_req_t apb_req,
   output apb_rsp_t apb_rsp,
   output sample_t  sig_out,
   output sample_t  mod_out,
   output symbol_t  symbol
);

   dds_ctrl_t  ctrl;    // register block settings
   waveforms_t waves;

   dds_regs #(
      .default_phase_inc (default_phase_inc),
      .tick_div_reset    (tick_div_reset)
   ) regs0 (
      .CLK_50M        (CLK_50M),
      .reset_from_key (reset_from_key),
      .apb_req        (apb_req),
      .apb_rsp        (apb_rsp),
      .symbol         (symbol),
      .ctrl           (ctrl)
   );

   symbol_gen #(
      .lfsr_seed (lfsr_seed)
   ) sym0 (
      .CLK_50M        (CLK_50M),
      .reset_from_key (reset_from_key),
      .tick_div       (ctrl.tick_div),
      .symbol         (symbol)
   );

   dds_core core0 (
      .CLK_50M        (CLK_50M),
      .reset_from_key (reset_from_key),
      .phase_inc      (ctrl.phase_inc),
      .waves          (waves)
   );

   modulator mod0 (
      .CLK_50M        (CLK_50M),
      .reset_from_key (reset_from_key),
      .waves          (waves),
      .symbol         (symbol),
      .wave_sel       (ctrl.wave_sel),
      .mod_sel        (ctrl.mod_sel),
      .sig_out        (sig_out),
      .mod_out        (mod_out)
   );

endmodule

`default_nettype wire

/* logic/dds_pkg.sv */
`default_nettype none

package dds_pkg;

   //////////////////////////////////////////////////
   // signal path widths
   //////////////////////////////////////////////////
   typedef logic [31:0] phase_t;    // accumulator value and increment
   typedef logic [11:0] sample_t;   // offset binary, mid scale 2048
   typedef logic [4:0]  symbol_t;   // lfsr state

   localparam sample_t sample_mid = 12'h800;

   // selector codes
   typedef logic [1:0] wave_sel_t;
   typedef logic [1:0] mod_sel_t;

   localparam wave_sel_t wave_sin = 2'd0;
   localparam wave_sel_t wave_cos = 2'd1;
   localparam wave_sel_t wave_saw = 2'd2;
   localparam wave_sel_t wave_squ = 2'd3;

   localparam mod_sel_t mod_ask  = 2'd0;
   localparam mod_sel_t mod_fsk  = 2'd1;
   localparam mod_sel_t mod_qpsk = 2'd2;
   localparam mod_sel_t mod_lfsr = 2'd3;   // raw lfsr bit

   //////////////////////////////////////////////////
   // bundles between blocks
   //////////////////////////////////////////////////
   typedef struct packed {
      sample_t sin;
      sample_t cos;
      sample_t squ;
      sample_t saw;
   } waveforms_t;

   typedef struct packed {
      wave_sel_t wave_sel;
      mod_sel_t  mod_sel;
      phase_t    phase_inc;
      phase_t    tick_div;   // symbol period in clocks
   } dds_ctrl_t;

endpackage

`default_nettype wire

/* logic/dds_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module dds_regs
   import dds_pkg::*;
   import apb_pkg::*;
#(
   parameter phase_t default_phase_inc = 32'd258,
   parameter phase_t tick_div_reset    = 32'd50_000_000
)
(
   input  wire       CLK_50M,
   input  wire       reset_from_key,
   input  wire       apb_req_t apb_req,
   output apb_rsp_t  apb_rsp,
   input  wire       symbol_t symbol,
   output dds_ctrl_t ctrl
);

   logic      access;     // second cycle of a transfer
   logic      wr_en;
   logic      rd_en;
   logic      addr_hit;
   apb_data_t rd_data;

   assign access = apb_req.psel && apb_req.penable;
   assign wr_en  = access && apb_req.pwrite;
   assign rd_en  = access && !apb_req.pwrite;

   //////////////////////////////////////////////////
   // address decode and read mux
   //////////////////////////////////////////////////
   always_comb
   begin
      addr_hit = 1'b1;
      rd_data  = '0;
      case (apb_req.paddr)
         ctrl_addr:      rd_data = {26'd0, ctrl.mod_sel, 2'd0, ctrl.wave_sel};
         phase_inc_addr: rd_data = ctrl.phase_inc;
         tick_div_addr:  rd_data = ctrl.tick_div;
         symbol_addr:    rd_data = {27'd0, symbol};
         default:        addr_hit = 1'b0;   // unmapped, reads as zero
      endcase
   end

   // zero wait states
   assign apb_rsp = '{prdata: rd_en ? rd_data : '0, pready: 1'b1, pslverr: access && !addr_hit};

   always_ff @(posedge CLK_50M)
   begin
      if (reset_from_key)
      begin
         ctrl.wave_sel  <= wave_sin;
         ctrl.mod_sel   <= mod_ask;
         ctrl.phase_inc <= default_phase_inc;
         ctrl.tick_div  <= tick_div_reset;
      end
      else if (wr_en)
      begin
         case (apb_req.paddr)
            ctrl_addr:
            begin
               ctrl.wave_sel <= wave_sel_t'(apb_req.pwdata[1:0]);
               ctrl.mod_sel  <= mod_sel_t'(apb_req.pwdata[5:4]);
            end
            phase_inc_addr: ctrl.phase_inc <= apb_req.pwdata;
            tick_div_addr:  ctrl.tick_div  <= apb_req.pwdata;
            default:        ;   // symbol is read only
         endcase
      end
   end

   // master side of the bus must never run an access phase without select
   apb_penable_needs_psel: assert property (@(posedge CLK_50M) disable iff (reset_from_key)
      apb_req.penable |-> apb_req.psel);

endmodule

`default_nettype wire

/* logic/modulator.sv */
`timescale 1ns/1ps
`default_nettype none

module modulator
   import dds_pkg::*;
(
   input  wire     CLK_50M,
   input  wire     reset_from_key,
   input  wire     waveforms_t waves,
   input  wire     symbol_t symbol,
   input  wire     wave_sel_t wave_sel,
   input  wire     mod_sel_t mod_sel,
   output sample_t sig_out,
   output sample_t mod_out
);

   sample_t sig_next;
   sample_t qpsk_sample;
   sample_t mod_next;

   always_comb
   begin
      case (wave_sel)
         wave_sin: sig_next = waves.sin;
         wave_cos: sig_next = waves.cos;
         wave_saw: sig_next = waves.saw;
         wave_squ: sig_next = waves.squ;
      endcase
   end

   // two symbol bits pick one of four carrier phases
   always_comb
   begin
      case (symbol[1:0])
         2'd0: qpsk_sample = waves.sin;
         2'd1: qpsk_sample = waves.cos;
         2'd2: qpsk_sample = ~waves.sin;   // offset binary, so ~ mirrors about mid scale
         2'd3: qpsk_sample = ~waves.cos;
      endcase
   end

   always_comb
   begin
      case (mod_sel)
         mod_ask:  mod_next = symbol[0] ? waves.sin : '0;
         mod_fsk:  mod_next = waves.sin;   // frequency comes from the phase_inc register
         mod_qpsk: mod_next = qpsk_sample;
         mod_lfsr: mod_next = symbol[0] ? sample_mid : '0;
      endcase
   end

   always_ff @(posedge CLK_50M)
   begin
      if (reset_from_key)
      begin
         sig_out <= '0;
         mod_out <= '0;
      end
      else
      begin
         sig_out <= sig_next;
         mod_out <= mod_next;
      end
   end

endmodule

`default_nettype wire

/* logic/symbol_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module symbol_gen
   import dds_pkg::*;
#(
   parameter symbol_t lfsr_seed = 5'd1
)
(
   input  wire     CLK_50M,
   input  wire     reset_from_key,
   input  wire     phase_t tick_div,
   output symbol_t symbol
);

   phase_t tick_cnt;
   logic   tick_wrap;

   // >= also catches a divider written below the running count
   assign tick_wrap = (tick_div != '0) && (tick_cnt >= tick_div - phase_t'(1));

   always_ff @(posedge CLK_50M)
   begin
      if (reset_from_key)
      begin
         tick_cnt <= '0;
         symbol   <= lfsr_seed;
      end
      else if (tick_div != '0)   // zero divider freezes both
      begin
         if (tick_wrap)
         begin
            tick_cnt <= '0;
            symbol   <= {symbol[3:0], symbol[4] ^ symbol[2]};   // x^5 + x^3 + 1
         end
         else
            tick_cnt <= tick_cnt + phase_t'(1);
      end
   end

   symbol_never_zero: assert property (@(posedge CLK_50M) disable iff (reset_from_key)
      symbol != '0);

   // one cycle of slack right after the divider is rewritten
   tick_cnt_in_range: assert property (@(posedge CLK_50M) disable iff (reset_from_key)
      (tick_div != '0) && $stable(tick_div) |-> tick_cnt < tick_div);

endmodule

`default_nettype wire
